/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = issue_execute_tb
FILELIST = all.f
BUILD_DIR = obj_dir

.PHONY: sim clean

# the exit status comes from the search for the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | awk '{ print } /^Testbench passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)

/* all.f */
hdl/issue_pkg.sv
hdl/latency_decoder.sv
hdl/execute_hazard_detect.sv
hdl/thread_select.sv
hdl/single_cycle_alu.sv
hdl/multi_cycle_pipeline.sv
hdl/execute_merge.sv
hdl/issue_execute_top.sv
verification/issue_execute_tb.sv

/* hdl/execute_hazard_detect.sv */
// protects the writeback merge only; assumes the mac path is exactly multi_extra_stages longer
`timescale 1ns/100ps
`default_nettype none

module execute_hazard_detect
	import issue_pkg::*;
(
	input wire clk,
	input wire reset_n,
	input wire [num_threads-1:0] single_cycle,
	input wire [num_threads-1:0] multi_cycle,
	input wire [num_threads-1:0] issue_oh,
	output logic [num_threads-1:0] execute_hazard
);

	// one bit per cycle of extra mac latency; a set bit means a mac result
	// will reach the merge in the slot a single-cycle op issued now would use
	logic [multi_extra_stages-1:0] merge_slot_busy;
	logic issued_multi_cycle;

	// issue_oh is one-hot or zero, so this is the class of the instruction
	// being granted this cycle
	assign issued_multi_cycle = |(issue_oh & multi_cycle);

	// a mac granted in cycle t shows up in the oldest bit in cycle t+3,
	// which is when a single-cycle op would finish together with it
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			merge_slot_busy <= '0;
		end
		else
		begin
			merge_slot_busy <= {merge_slot_busy[multi_extra_stages-2:0], issued_multi_cycle};
		end
	end

	// only single-cycle candidates are held back
	// a mac or nop candidate can still issue in the busy slot
	assign execute_hazard = {num_threads{merge_slot_busy[multi_extra_stages-1]}} & single_cycle;

endmodule

`default_nettype wire

/* hdl/execute_merge.sv */
// registered writeback mux with no arbitration; relies on the hazard tracker to keep inputs apart
`timescale 1ns/100ps
`default_nettype none

module execute_merge
	import issue_pkg::*;
(
	input wire clk,
	input wire reset_n,
	input wire writeback_t single_result,
	input wire writeback_t multi_result,
	output writeback_t writeback
);

	writeback_t selected;

	// the mac path takes priority, though both valid together cannot happen
	// while single-cycle issue is held off in the matching slot
	always_comb
	begin
		if (multi_result.valid)
		begin
			selected = multi_result;
		end
		else
		begin
			// when neither is valid this passes an invalid word through
			selected = single_result;
		end
	end

	// the writeback port has no ready signal, every valid result is taken
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			writeback <= '0;
		end
		else
		begin
			writeback <= selected;
		end
	end

endmodule

`default_nettype wire

/* hdl/issue_execute_top.sv */
// issue and execute slice top; threads hold instruction while valid, writeback has no back-pressure
`timescale 1ns/100ps
`default_nettype none

module issue_execute_top
	import issue_pkg::*;
(
	input wire clk,
	input wire reset_n,
	input wire instruction_t instruction [num_threads],
	input wire [num_threads-1:0] thread_valid,
	output logic [num_threads-1:0] issue_ack,
	output writeback_t writeback
);

	logic [num_threads-1:0] single_cycle;
	logic [num_threads-1:0] multi_cycle;
	logic [num_threads-1:0] execute_hazard;
	logic [num_threads-1:0] eligible;
	logic [num_threads-1:0] issue_oh;
	thread_id_t issue_thread;
	exec_op_t exec_op;
	writeback_t single_result;
	writeback_t multi_result;

	// one classifier per thread, shared by the hazard tracker and the path accepts
	for (genvar i = 0; i < num_threads; i++)
	begin : decode
		latency_decoder decoder (
			.instruction(instruction[i]),
			.single_cycle_result(single_cycle[i]),
			.multi_cycle_result(multi_cycle[i])
		);
	end

	execute_hazard_detect hazard_detect (
		.clk(clk),
		.reset_n(reset_n),
		.single_cycle(single_cycle),
		.multi_cycle(multi_cycle),
		.issue_oh(issue_oh),
		.execute_hazard(execute_hazard)
	);

	// a hazarded thread simply sits out this cycle's arbitration
	assign eligible = thread_valid & ~execute_hazard;

	thread_select selector (
		.clk(clk),
		.reset_n(reset_n),
		.eligible(eligible),
		.issue_oh(issue_oh),
		.issue_thread(issue_thread)
	);

	assign issue_ack = issue_oh;

	// the same operation goes to both paths, each accepts only its own class
	assign exec_op = '{valid: |issue_oh, thread: issue_thread,
		instruction: instruction[issue_thread]};

	single_cycle_alu alu (
		.clk(clk),
		.reset_n(reset_n),
		.op(exec_op),
		.accept(single_cycle[issue_thread]),
		.result(single_result)
	);

	multi_cycle_pipeline mac_pipe (
		.clk(clk),
		.reset_n(reset_n),
		.op(exec_op),
		.accept(multi_cycle[issue_thread]),
		.result(multi_result)
	);

	execute_merge merge (
		.clk(clk),
		.reset_n(reset_n),
		.single_result(single_result),
		.multi_result(multi_result),
		.writeback(writeback)
	);

endmodule

`default_nettype wire

/* hdl/issue_pkg.sv */
// shared types for the four-thread issue slice; depths are fixed here, unused opcodes act as nop
`default_nettype none

package issue_pkg;

	// number of hardware thread slots offering instructions to the issue stage
	localparam int num_threads = 4;

	typedef logic [$clog2(num_threads)-1:0] thread_id_t;

	// opcode values not listed here decode as nop and never write back
	typedef enum logic [3:0] {
		nop = 4'd0,
		add = 4'd1,
		sub = 4'd2,
		op_and = 4'd3,
		op_xor = 4'd4,
		mac = 4'd8
	} opcode_t;

	// two 12-bit immediates for the short operations
	typedef struct packed {
		opcode_t opcode;
		logic [3:0] dest;
		logic [11:0] operand_a;
		logic [11:0] operand_b;
	} alu_form_t;

	// the multiply-accumulate computes mul_a * mul_b + addend
	typedef struct packed {
		opcode_t opcode;
		logic [3:0] dest;
		logic [7:0] mul_a;
		logic [7:0] mul_b;
		logic [7:0] addend;
	} mac_form_t;

	// the opcode sits in bits 31:28 in both forms, so either view can be used to decode it
	typedef union packed {
		alu_form_t alu_fields;
		mac_form_t mac_fields;
	} instruction_t;

	// cycles from the grant cycle to writeback valid for a single-cycle operation
	localparam int single_latency = 3;

	// extra cycles on the mac path, which is also the depth of the hazard tracker
	localparam int multi_extra_stages = 3;

	// results are zero-extended; sub wraps modulo 2^24
	typedef logic [23:0] result_t;

	typedef struct packed {
		logic valid;
		thread_id_t thread;
		logic [3:0] dest;
		result_t result;
	} writeback_t;

	// one issued operation as it leaves the selector towards both execute paths
	typedef struct packed {
		logic valid;
		thread_id_t thread;
		instruction_t instruction;
	} exec_op_t;

endpackage

`default_nettype wire

/* hdl/latency_decoder.sv */
// pure combinational opcode classifier; any opcode outside the alu set and mac counts as neither
`timescale 1ns/100ps
`default_nettype none

module latency_decoder
	import issue_pkg::*;
(
	input wire instruction_t instruction,
	output logic single_cycle_result,
	output logic multi_cycle_result
);

	// the opcode field is at the same place in both instruction forms,
	// so the alu view is enough to classify the word
	always_comb
	begin
		case (instruction.alu_fields.opcode)
			add, sub, op_and, op_xor:
			begin
				single_cycle_result = 1'b1;
				multi_cycle_result = 1'b0;
			end
			mac:
			begin
				single_cycle_result = 1'b0;
				multi_cycle_result = 1'b1;
			end
			default:
			begin
				// nop and every unused encoding issue without a writeback
				single_cycle_result = 1'b0;
				multi_cycle_result = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* hdl/multi_cycle_pipeline.sv */
// fully pipelined unsigned 8x8 multiply plus 8-bit addend; accepts one new mac every cycle
`timescale 1ns/100ps
`default_nettype none

module multi_cycle_pipeline
	import issue_pkg::*;
(
	input wire clk,
	input wire reset_n,
	input wire exec_op_t op,
	input wire accept,
	output writeback_t result
);

	// thread and dest ride alongside the data through every stage
	typedef struct packed {
		thread_id_t thread;
		logic [3:0] dest;
	} mac_tag_t;

	// index 0 is the issue register, 1 to 4 are the mac stages
	logic [4:0] valid_pipe;
	mac_tag_t tag_pipe [5];

	mac_form_t issue_fields;
	logic [7:0] s1_mul_a;
	logic [7:0] s1_mul_b;
	logic [7:0] s1_addend;
	logic [11:0] s2_partial_low;
	logic [11:0] s2_partial_high;
	logic [7:0] s2_addend;
	logic [15:0] s3_product;
	logic [7:0] s3_addend;
	result_t s4_value;

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			valid_pipe <= '0;
		end
		else
		begin
			valid_pipe <= {valid_pipe[3:0], op.valid & accept};
		end
	end

	always_ff @(posedge clk)
	begin
		if (op.valid && accept)
		begin
			tag_pipe[0] <= '{thread: op.thread, dest: op.instruction.mac_fields.dest};
			issue_fields <= op.instruction.mac_fields;
		end
		for (int i = 1; i < 5; i++)
		begin
			tag_pipe[i] <= tag_pipe[i-1];
		end

		// stage 1 latches the operands out of the issue register
		s1_mul_a <= issue_fields.mul_a;
		s1_mul_b <= issue_fields.mul_b;
		s1_addend <= issue_fields.addend;

		// stage 2 splits the multiplier into two nibbles, one partial product each
		s2_partial_low <= s1_mul_a * s1_mul_b[3:0];
		s2_partial_high <= s1_mul_a * s1_mul_b[7:4];
		s2_addend <= s1_addend;

		// stage 3 recombines the partial products into the full 16-bit product
		s3_product <= 16'(s2_partial_low) + {s2_partial_high, 4'b0000};
		s3_addend <= s2_addend;

		// stage 4 accumulates, the sum never exceeds 16 bits so nothing wraps
		s4_value <= result_t'(s3_product) + result_t'(s3_addend);
	end

	assign result = '{valid: valid_pipe[4], thread: tag_pipe[4].thread, dest: tag_pipe[4].dest,
		result: s4_value};

endmodule

`default_nettype wire

/* hdl/single_cycle_alu.sv */
// two-register short path for add, sub, and, xor; operands are taken as unsigned 12-bit values
`timescale 1ns/100ps
`default_nettype none

module single_cycle_alu
	import issue_pkg::*;
(
	input wire clk,
	input wire reset_n,
	input wire exec_op_t op,
	input wire accept,
	output writeback_t result
);

	logic issue_valid;
	thread_id_t issue_thread;
	alu_form_t issue_fields;

	logic alu_valid;
	thread_id_t alu_thread;
	logic [3:0] alu_dest;
	result_t alu_value;
	result_t next_value;

	// the valid bits track which of the two stages holds a live operation
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			issue_valid <= 1'b0;
			alu_valid <= 1'b0;
		end
		else
		begin
			issue_valid <= op.valid & accept;
			alu_valid <= issue_valid;
		end
	end

	// the issue register only loads when this path owns the operation
	always_ff @(posedge clk)
	begin
		if (op.valid && accept)
		begin
			issue_thread <= op.thread;
			issue_fields <= op.instruction.alu_fields;
		end
	end

	// operands are widened first so that sub wraps in the full result width
	always_comb
	begin
		case (issue_fields.opcode)
			add: next_value = result_t'(issue_fields.operand_a) + result_t'(issue_fields.operand_b);
			sub: next_value = result_t'(issue_fields.operand_a) - result_t'(issue_fields.operand_b);
			op_and: next_value = result_t'(issue_fields.operand_a & issue_fields.operand_b);
			op_xor: next_value = result_t'(issue_fields.operand_a ^ issue_fields.operand_b);
			default: next_value = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		alu_thread <= issue_thread;
		alu_dest <= issue_fields.dest;
		alu_value <= next_value;
	end

	assign result = '{valid: alu_valid, thread: alu_thread, dest: alu_dest, result: alu_value};

endmodule

`default_nettype wire

/* hdl/thread_select.sv */
// combinational round-robin grant; eligible must already exclude hazarded threads
`timescale 1ns/100ps
`default_nettype none

module thread_select
	import issue_pkg::*;
(
	input wire clk,
	input wire reset_n,
	input wire [num_threads-1:0] eligible,
	output logic [num_threads-1:0] issue_oh,
	output thread_id_t issue_thread
);

	// thread with the highest priority in the next search
	thread_id_t rr_pointer;

	// walk the threads starting at the pointer and take the first eligible one
	always_comb
	begin
		thread_id_t candidate;
		logic found;

		issue_oh = '0;
		found = 1'b0;

		// with nothing eligible the index is a don't care, since the
		// issued operation is marked invalid at the top
		issue_thread = rr_pointer;

		for (int i = 0; i < num_threads; i++)
		begin
			// the index wraps naturally in the thread id width
			candidate = rr_pointer + thread_id_t'(i);
			if (!found && eligible[candidate])
			begin
				found = 1'b1;
				issue_thread = candidate;
				issue_oh[candidate] = 1'b1;
			end
		end
	end

	// after a grant the thread just served drops to the lowest priority,
	// an idle cycle leaves the order unchanged
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			rr_pointer <= '0;
		end
		else if (|eligible)
		begin
			rr_pointer <= issue_thread + thread_id_t'(1);
		end
	end

endmodule

`default_nettype wire

/* verification/issue_execute_tb.sv */
// seeded random traffic on all four threads; expects writeback at ack+3 for alu ops and ack+6 for mac
`timescale 1ns/100ps
`default_nettype none

module issue_execute_tb
	import issue_pkg::*;
();

	localparam int words_per_thread = 24;
	localparam int total_words = num_threads * words_per_thread;
	localparam int timeout_cycles = total_words * 8 + 100;
	localparam int slot_count = timeout_cycles + 16;
	localparam int test_count = 6;

	logic clk = 1'b0;
	logic reset_n;
	instruction_t instruction [num_threads];
	logic [num_threads-1:0] thread_valid;
	logic [num_threads-1:0] issue_ack;
	writeback_t writeback;

	integer seed = 69532;
	instruction_t program_words [num_threads][words_per_thread];
	int next_word [num_threads];
	logic reset_window;
	logic [num_threads-1:0] acked_last;

	// model state lives on the falling edge so the rising-edge checks see it settled
	int cycle = 0;
	int run_cycles = 0;
	int rr_pointer = 0;
	writeback_t expected_at [slot_count];
	logic mac_due_at [slot_count];
	logic mac_hazard_at [slot_count];
	writeback_t expected_wb;
	logic expected_is_mac;
	logic hazard_slot;
	logic [num_threads-1:0] single_mask;
	logic [num_threads-1:0] expected_ack;
	logic last_ack_mac;
	int last_ack_thread;
	int wb_expected;
	int wb_seen;
	int back_to_back_macs;
	int hazard_other;
	string test_name [test_count] = '{"reset_state", "single_cycle_results", "mac_results",
		"nop_and_presence", "hazard_rule", "grant_rule"};
	int test_errors [test_count];
	int test_reach [test_count];

	issue_execute_top DUT (
		.clk(clk),
		.reset_n(reset_n),
		.instruction(instruction),
		.thread_valid(thread_valid),
		.issue_ack(issue_ack),
		.writeback(writeback)
	);

	always #20 clk = ~clk;

	function automatic logic is_alu_op(input instruction_t word);
		return word[31:28] >= 4'd1 && word[31:28] <= 4'd4;
	endfunction

	function automatic logic is_mac_op(input instruction_t word);
		return word[31:28] == 4'd8;
	endfunction

	// zero-extended operands, so sub wraps modulo 2^24
	function automatic result_t expected_result(input instruction_t word);
		result_t a;
		result_t b;
		result_t product;
		a = {12'd0, word.alu_fields.operand_a};
		b = {12'd0, word.alu_fields.operand_b};
		product = {16'd0, word.mac_fields.mul_a} * {16'd0, word.mac_fields.mul_b};
		case (word[31:28])
			4'd1: return a + b;
			4'd2: return a - b;
			4'd3: return a & b;
			4'd4: return a ^ b;
			4'd8: return product + {16'd0, word.mac_fields.addend};
			default: return '0;
		endcase
	endfunction

	// a third of the words are mac so that merge slots get blocked often
	function automatic instruction_t random_instruction();
		logic [31:0] word;
		int pick;
		int unused_code;
		word = $random(seed);
		pick = $unsigned($random(seed)) % 12;
		unused_code = $unsigned($random(seed)) % 10;
		case (pick)
			0, 1, 2, 3: word[31:28] = 4'd8;
			4, 5: word[31:28] = 4'd1;
			6, 11: word[31:28] = 4'd2;
			7: word[31:28] = 4'd3;
			8: word[31:28] = 4'd4;
			9: word[31:28] = 4'd0;
			// codes 5 to 7 and 9 to 15
			default: word[31:28] = 4'(unused_code < 3 ? unused_code + 5 : unused_code + 6);
		endcase
		return instruction_t'(word);
	endfunction

	task automatic record_mismatch(input int test, input logic [63:0] expected,
		input logic [63:0] actual);
		test_errors[test]++;
		$display("Fail %s: expected %h, actual %h", test_name[test], expected, actual);
	endtask

	task automatic record_problem(input int test, input string what);
		test_errors[test]++;
		$display("Error in %s: %s", test_name[test], what);
	endtask

	// a consumed word is replaced or the thread goes idle, at random
	task automatic drive_threads();
		for (int t = 0; t < num_threads; t++)
		begin
			if (thread_valid[t] && acked_last[t])
				thread_valid[t] = 1'b0;
			if (!thread_valid[t] && next_word[t] < words_per_thread && ($random(seed) & 3) != 0)
			begin
				instruction[t] = program_words[t][next_word[t]];
				next_word[t]++;
				thread_valid[t] = 1'b1;
			end
		end
	endtask

	reset_quiet: assert property (@(posedge clk) reset_window |->
		(!writeback.valid && issue_ack == '0))
		else record_mismatch(0, 64'(0), 64'($sampled({writeback.valid, issue_ack})));
	wb_presence: assert property (@(posedge clk) disable iff (!reset_n)
		writeback.valid == expected_wb.valid)
		else record_mismatch(3, 64'($sampled(expected_wb.valid)), 64'($sampled(writeback.valid)));
	alu_result: assert property (@(posedge clk) disable iff (!reset_n)
		(expected_wb.valid && !expected_is_mac) |-> writeback == expected_wb)
		else record_mismatch(1, 64'($sampled(expected_wb)), 64'($sampled(writeback)));
	mac_result: assert property (@(posedge clk) disable iff (!reset_n)
		(expected_wb.valid && expected_is_mac) |-> writeback == expected_wb)
		else record_mismatch(2, 64'($sampled(expected_wb)), 64'($sampled(writeback)));
	hazard_single: assert property (@(posedge clk) disable iff (!reset_n)
		hazard_slot |-> (issue_ack & single_mask) == '0)
		else record_problem(4, "a single-cycle thread was granted in a mac merge slot");
	hazard_others: assert property (@(posedge clk) disable iff (!reset_n)
		(hazard_slot && (thread_valid & ~single_mask) != '0) |-> issue_ack != '0)
		else record_problem(4, "an eligible nop or mac thread was not granted in a mac slot");
	grant_legal: assert property (@(posedge clk) disable iff (!reset_n)
		$onehot0(issue_ack) && (issue_ack & ~thread_valid) == '0)
		else record_problem(5, "issue_ack was not one-hot or went to an idle thread");
	grant_order: assert property (@(posedge clk) disable iff (!reset_n) issue_ack == expected_ack)
		else record_mismatch(5, 64'($sampled(expected_ack)), 64'($sampled(issue_ack)));

	always @(posedge clk)
	begin
		run_cycles <= run_cycles + 1;
		if (reset_n)
			cycle <= cycle + 1;
		// one reset check is made on every rising edge inside the window
		if (reset_window)
			test_reach[0]++;
		if (run_cycles >= timeout_cycles)
		begin
			$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	always @(negedge clk)
	begin : reference_model
		logic [num_threads-1:0] eligible;
		logic found;
		int index;
		int ack_thread;
		int slot;
		instruction_t word;

		if (reset_n)
		begin
			expected_wb = expected_at[cycle];
			expected_is_mac = mac_due_at[cycle];
			hazard_slot = mac_hazard_at[cycle];
			for (int t = 0; t < num_threads; t++)
			begin
				single_mask[t] = is_alu_op(instruction[t]);
			end
			eligible = thread_valid & ~(hazard_slot ? single_mask : '0);
			// first eligible thread at or after the pointer wins
			expected_ack = '0;
			found = 1'b0;
			for (int i = 0; i < num_threads; i++)
			begin
				index = (rr_pointer + i) % num_threads;
				if (!found && eligible[index])
				begin
					found = 1'b1;
					expected_ack[index] = 1'b1;
					rr_pointer = (index + 1) % num_threads;
				end
			end
			if (expected_wb.valid)
				test_reach[expected_is_mac ? 2 : 1]++;
			if (hazard_slot && (thread_valid & single_mask) != '0)
				test_reach[4]++;
			if (hazard_slot && (thread_valid & ~single_mask) != '0)
				hazard_other++;
			if ($countones(eligible) > 1)
				test_reach[5]++;
			ack_thread = -1;
			for (int t = 0; t < num_threads; t++)
			begin
				if (issue_ack[t])
					ack_thread = t;
			end
			if (ack_thread >= 0)
			begin
				word = instruction[ack_thread];
				if (is_alu_op(word) || is_mac_op(word))
				begin
					slot = cycle + single_latency + (is_mac_op(word) ? multi_extra_stages : 0);
					if (expected_at[slot].valid)
						record_problem(4, "two results are due at the merge in one cycle");
					expected_at[slot] = '{valid: 1'b1, thread: thread_id_t'(ack_thread),
						dest: word.alu_fields.dest, result: expected_result(word)};
					mac_due_at[slot] = is_mac_op(word);
					wb_expected++;
				end
				else
					test_reach[3]++;
				if (is_mac_op(word))
				begin
					mac_hazard_at[cycle + multi_extra_stages] = 1'b1;
					if (last_ack_mac && last_ack_thread != ack_thread)
						back_to_back_macs++;
				end
				last_ack_mac = is_mac_op(word);
				last_ack_thread = ack_thread;
			end
			else
				last_ack_mac = 1'b0;
			acked_last = issue_ack;
			if (writeback.valid)
				wb_seen++;
		end
	end

	initial
	begin : stimulus
		int errors;
		int failed_tests;

		reset_n = 1'b0;
		thread_valid = '0;
		reset_window = 1'b1;
		acked_last = '0;
		expected_wb = '0;
		expected_is_mac = 1'b0;
		hazard_slot = 1'b0;
		single_mask = '0;
		expected_ack = '0;
		last_ack_mac = 1'b0;
		last_ack_thread = 0;
		for (int s = 0; s < slot_count; s++)
		begin
			expected_at[s] = '0;
			mac_due_at[s] = 1'b0;
			mac_hazard_at[s] = 1'b0;
		end
		for (int t = 0; t < num_threads; t++)
		begin
			instruction[t] = '0;
			next_word[t] = 0;
			for (int w = 0; w < words_per_thread; w++)
			begin
				program_words[t][w] = random_instruction();
			end
		end
		repeat (8) @(posedge clk);
		#2;
		reset_n = 1'b1;
		// all threads stay idle through the first cycle out of reset
		@(posedge clk);
		#2;
		reset_window = 1'b0;
		$display("%s: %0d checks reached, %0d errors", test_name[0], test_reach[0], test_errors[0]);
		drive_threads();
		while (thread_valid != '0 || next_word.sum() < total_words)
		begin
			@(posedge clk);
			#2;
			drive_threads();
		end
		while (wb_seen < wb_expected)
			@(posedge clk);
		// longer than the mac latency, so a stray writeback still shows up
		repeat (8) @(posedge clk);
		if (wb_seen != wb_expected)
			record_mismatch(3, 64'(wb_expected), 64'(wb_seen));
		if (back_to_back_macs == 0)
			record_problem(2, "no back-to-back macs from different threads were issued");
		if (hazard_other == 0)
			record_problem(4, "no nop or mac thread was eligible in a mac merge slot");
		errors = test_errors[0];
		failed_tests = test_errors[0] != 0;
		for (int i = 1; i < test_count; i++)
		begin
			if (test_reach[i] == 0)
				record_problem(i, "the stimulus never reached this check");
			$display("%s: %0d checks reached, %0d errors", test_name[i], test_reach[i],
				test_errors[i]);
			errors += test_errors[i];
			failed_tests += test_errors[i] != 0;
		end
		$display("Summary: %0d tests, %0d failed, %0d errors, %0d words, %0d writebacks",
			test_count, failed_tests, errors, total_words, wb_seen);
		if (errors == 0)
		begin
			$display("Testbench passed");
		end
		else
		begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
